// File: wb_ic_pkg.sv
// Shared definitions for the 1x4 Wishbone classic interconnect
// Request and response bundles, target index and the slave address map
package wb_ic_pkg;

	// Bus widths
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W  = 4;

	// Number of real slaves behind the interconnect
	localparam int N_SLAVES = 4;

	// One master request as it travels to a slave port
	// Field order puts the address in the top bits
	typedef struct packed {
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat_w;
		logic [WB_SEL_W-1:0]  sel;
		logic                 we;
		// Cycle type and burst type are passed through untouched
		logic [2:0]           cti;
		logic [1:0]           bte;
		logic                 cyc;
		logic                 stb;
	} wb_req_t;

	// One slave response back toward the master
	typedef struct packed {
		logic [WB_DATA_W-1:0] dat_r;
		logic                 ack;
		logic                 err;
	} wb_rsp_t;

	// Index of the current target
	// Values 0 to 3 name the real slaves
	typedef logic [2:0] target_t;

	// Built-in slave that ends unmapped accesses with ERR
	localparam target_t TGT_DECODE_ERR = 3'd4;

	// No cycle open
	localparam target_t TGT_NONE = 3'd7;

	// Inclusive window bounds per slave
	// Lowest matching index wins when windows overlap
	localparam logic [WB_ADDR_W-1:0] SLV_BASE [N_SLAVES] = '{
		32'h0000_0000,
		32'h0000_1000,
		32'h0001_0000,
		32'h8000_0000
	};

	localparam logic [WB_ADDR_W-1:0] SLV_LIMIT [N_SLAVES] = '{
		32'h0000_0FFF,
		32'h0000_1FFF,
		32'h0001_00FF,
		32'h8000_FFFF
	};

endpackage

// File: wb_addr_decode.sv
`timescale 1ns/1ps
// Address decode stage of the 1x4 Wishbone interconnect
// Latches the target of a new cycle and holds it until ACK or ERR ends it
module wb_addr_decode (
	input  logic               clk,
	input  logic               rstn,
	input  wb_ic_pkg::wb_req_t m_req_i,
	input  wb_ic_pkg::wb_rsp_t m_rsp_i,
	output wb_ic_pkg::target_t target_o
);
	import wb_ic_pkg::*;

	// Two states only
	// Idle waits for a strobe and busy holds the latched target
	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} state_t;

	state_t  state;
	target_t target;

	// Combinational window match for the current address
	target_t match;

	// Master has a strobe up
	logic strobe;

	// Selected target has answered
	logic done;

	// Map an address to a slave index by the window rule
	// Scanning from the top down leaves the lowest match in place
	function automatic target_t addr_to_target(input logic [WB_ADDR_W-1:0] adr);
		target_t tgt;

		tgt = TGT_DECODE_ERR;
		for (int k = N_SLAVES - 1; k >= 0; k--) begin
			if ((adr >= SLV_BASE[k]) && (adr <= SLV_LIMIT[k])) begin
				tgt = target_t'(k);
			end
		end
		return tgt;
	endfunction

	assign strobe = m_req_i.cyc && m_req_i.stb;

	// Response seen here is already filtered by the response select
	assign done = m_rsp_i.ack || m_rsp_i.err;

	assign match = addr_to_target(m_req_i.adr);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state  <= ST_IDLE;
			target <= TGT_NONE;
		end else begin
			case (state)
				ST_IDLE: begin
					// Address is stable while the strobe is up
					// so one sample is enough
					if (strobe) begin
						state  <= ST_BUSY;
						target <= match;
					end
				end
				ST_BUSY: begin
					// Slave may stall for any number of cycles
					// Release the target only when the cycle ends
					if (done) begin
						state  <= ST_IDLE;
						target <= TGT_NONE;
					end
				end
			endcase
		end
	end

	// Idle cycle after each completion keeps a held strobe
	// from being taken as a second access
	assign target_o = target;

endmodule

// File: wb_req_router.sv
`timescale 1ns/1ps
// Request router of the 1x4 Wishbone interconnect
// Forwards the master request to the latched target and zeroes every other port
module wb_req_router (
	input  wb_ic_pkg::wb_req_t m_req_i,
	input  wb_ic_pkg::target_t target_i,
	output wb_ic_pkg::wb_req_t s_req_o [wb_ic_pkg::N_SLAVES],
	output wb_ic_pkg::wb_req_t err_req_o
);
	import wb_ic_pkg::*;

	// One-hot port select decoded from the target index
	logic [N_SLAVES-1:0] slv_sel;

	// Decode-error target selected
	logic err_sel;

	// Compare against each slave index
	// TGT_NONE matches nothing so all selects stay low
	always_comb begin
		for (int k = 0; k < N_SLAVES; k++) begin
			slv_sel[k] = (target_i == target_t'(k));
		end
	end

	assign err_sel = (target_i == TGT_DECODE_ERR);

	// Slave port drive
	// Whole request is copied so address data and select all line up
	// Idle ports see all zeros and never a stray cyc or stb
	always_comb begin
		for (int k = 0; k < N_SLAVES; k++) begin
			if (slv_sel[k]) begin
				s_req_o[k] = m_req_i;
			end else begin
				s_req_o[k] = '0;
			end
		end
	end

	// Decode-error port
	// Gets the request only for unmapped addresses
	always_comb begin
		if (err_sel) begin
			err_req_o = m_req_i;
		end else begin
			err_req_o = '0;
		end
	end

endmodule

// File: wb_decode_err.sv
`timescale 1ns/1ps
// Decode-error target of the 1x4 Wishbone interconnect
// Answers any access routed to it with a single-cycle ERR
module wb_decode_err (
	input  logic               clk,
	input  logic               rstn,
	input  wb_ic_pkg::wb_req_t req_i,
	output wb_ic_pkg::wb_rsp_t rsp_o
);
	import wb_ic_pkg::*;

	// Strobe seen on the error port
	logic strobe;

	// High for exactly one cycle per access
	logic pending;

	// Router keeps this port at zero unless the target is unmapped
	assign strobe = req_i.cyc && req_i.stb;

	// Raise one cycle after the strobe and drop after one cycle
	// The decode stage releases the target on the same edge
	always_ff @(posedge clk) begin
		if (!rstn) begin
			pending <= 1'b0;
		end else begin
			pending <= strobe && !pending;
		end
	end

	// Never ACK and never return data
	always_comb begin
		rsp_o       = '0;
		rsp_o.err   = pending;
		rsp_o.ack   = 1'b0;
		rsp_o.dat_r = '0;
	end

	// Writes to unmapped space are dropped
	// Reads return zero with ERR

endmodule

// File: wb_rsp_select.sv
`timescale 1ns/1ps
// Response select of the 1x4 Wishbone interconnect
// Returns the latched target's response to the master and zero otherwise
module wb_rsp_select (
	input  wb_ic_pkg::target_t target_i,
	input  wb_ic_pkg::wb_rsp_t s_rsp_i [wb_ic_pkg::N_SLAVES],
	input  wb_ic_pkg::wb_rsp_t err_rsp_i,
	output wb_ic_pkg::wb_rsp_t m_rsp_o
);
	import wb_ic_pkg::*;

	// One-hot select of the responding slave
	logic [N_SLAVES-1:0] slv_sel;

	// Decode-error target responding
	logic err_sel;

	// Same index compare as the router
	// so request and response always pair up
	always_comb begin
		for (int k = 0; k < N_SLAVES; k++) begin
			slv_sel[k] = (target_i == target_t'(k));
		end
	end

	assign err_sel = (target_i == TGT_DECODE_ERR);

	// AND-OR mux over the five sources
	// At most one select is high at a time
	// Under TGT_NONE the output is all zero
	// so an idle slave's ack never reaches the master
	always_comb begin
		m_rsp_o = '0;
		for (int k = 0; k < N_SLAVES; k++) begin
			if (slv_sel[k]) begin
				m_rsp_o = m_rsp_o | s_rsp_i[k];
			end
		end
		if (err_sel) begin
			m_rsp_o = m_rsp_o | err_rsp_i;
		end
	end

	// Data is passed on whole
	// A slave that reports ERR keeps its own dat_r

endmodule

// File: wb_interconnect_1x4.sv
`timescale 1ns/1ps
// Wishbone classic interconnect with one master and four slaves
// Decode then route then target then response select
module wb_interconnect_1x4 (
	input  logic               clk,
	input  logic               rstn,
	input  wb_ic_pkg::wb_req_t m_req_i,
	output wb_ic_pkg::wb_rsp_t m_rsp_o,
	output wb_ic_pkg::wb_req_t s_req_o [wb_ic_pkg::N_SLAVES],
	input  wb_ic_pkg::wb_rsp_t s_rsp_i [wb_ic_pkg::N_SLAVES]
);
	import wb_ic_pkg::*;

	// Latched target of the open cycle
	target_t target;

	// Request and response of the built-in error target
	wb_req_t err_req;
	wb_rsp_t err_rsp;

	// Target latch
	// Watches the master response to see the cycle end
	wb_addr_decode u_decode (
		.clk      (clk),
		.rstn     (rstn),
		.m_req_i  (m_req_i),
		.m_rsp_i  (m_rsp_o),
		.target_o (target)
	);

	// Request fan-out to the four slaves and the error target
	wb_req_router u_router (
		.m_req_i   (m_req_i),
		.target_i  (target),
		.s_req_o   (s_req_o),
		.err_req_o (err_req)
	);

	// Unmapped addresses end here
	wb_decode_err u_decode_err (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (err_req),
		.rsp_o (err_rsp)
	);

	// Response mux back to the master
	wb_rsp_select u_rsp_select (
		.target_i  (target),
		.s_rsp_i   (s_rsp_i),
		.err_rsp_i (err_rsp),
		.m_rsp_o   (m_rsp_o)
	);

endmodule

// File: wb_ic_sva.sv
`timescale 1ns/1ps
// Protocol assertions bound to the 1x4 Wishbone interconnect
module wb_ic_sva (
	input logic               clk,
	input logic               rstn,
	input wb_ic_pkg::wb_rsp_t m_rsp_o,
	input wb_ic_pkg::wb_req_t s_req_o [wb_ic_pkg::N_SLAVES]
);
	import wb_ic_pkg::*;

	logic [N_SLAVES-1:0] stb_vec;

	always_comb begin
		for (int k = 0; k < N_SLAVES; k++)
			stb_vec[k] = s_req_o[k].cyc && s_req_o[k].stb;
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!rstn) $onehot0(stb_vec))
		else $error("more than one slave port strobed");

	a_ack_err: assert property (@(posedge clk) disable iff (!rstn)
		!(m_rsp_o.ack && m_rsp_o.err))
		else $error("ack and err high together");

	// Waiting request must hold every field
	for (genvar k = 0; k < N_SLAVES; k++) begin : g_stable
		a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
			(stb_vec[k] && !m_rsp_o.ack && !m_rsp_o.err) |=> $stable(s_req_o[k]))
			else $error("slave port request changed while waiting");
	end

endmodule

bind wb_interconnect_1x4 wb_ic_sva u_sva (
	.clk     (clk),
	.rstn    (rstn),
	.m_rsp_o (m_rsp_o),
	.s_req_o (s_req_o)
);

// File: wb_ic_checker.sv
`timescale 1ns/1ps
// Scoreboard for the 1x4 Wishbone interconnect
// Predicts target and read data for every access and compares at completion
module wb_ic_checker (
	input  logic               clk,
	input  logic               rstn,
	input  wb_ic_pkg::wb_req_t m_req_i,
	input  wb_ic_pkg::wb_rsp_t m_rsp_i,
	input  wb_ic_pkg::wb_req_t s_req_i [wb_ic_pkg::N_SLAVES],
	output int                 tests_o,
	output int                 errors_o
);
	import wb_ic_pkg::*;

	// Expected contents of every slave memory
	logic [31:0] shadow [N_SLAVES][16384];
	int tests;
	int errors;
	// A strobe has been seen since reset
	bit seen_strobe;
	// Named slave carried the request during this access
	bit routed;

	// Expected target from the address windows
	function automatic int expected_target(input logic [31:0] adr);
		if (adr <= 32'h0000_0FFF)
			return 0;
		if (adr >= 32'h0000_1000 && adr <= 32'h0000_1FFF)
			return 1;
		if (adr >= 32'h0001_0000 && adr <= 32'h0001_00FF)
			return 2;
		if (adr >= 32'h8000_0000 && adr <= 32'h8000_FFFF)
			return 3;
		return 4;
	endfunction

	// Power-up contents, a function of the full byte address
	function automatic logic [31:0] fill_word(input logic [31:0] adr);
		return adr ^ 32'h5EED_0000 ^ (adr << 7);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		errors++;
	endtask

	// Whole request bundle on a slave port
	task automatic report_req_mismatch(input string name, input wb_req_t got,
			input wb_req_t exp);
		$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		errors++;
	endtask

	initial begin
		tests = 0;
		errors = 0;
		seen_strobe = 0;
		routed = 0;
		for (int k = 0; k < N_SLAVES; k++) begin
			for (int i = 0; i < 16384; i++) begin
				shadow[k][i] = fill_word({SLV_BASE[k][31:16], i[13:0], 2'b00});
			end
		end
	end

	// Sampled on the rising edge, inputs move on the falling edge
	always @(posedge clk) begin
		int tgt;
		int n_err;
		logic [31:0] exp_dat;
		if (rstn) begin
			tgt = expected_target(m_req_i.adr);
			if (!seen_strobe && (m_rsp_i.ack || m_rsp_i.err)) begin
				$display("Response seen before any strobe at t=%0t", $time);
				errors++;
			end
			if (m_req_i.cyc && m_req_i.stb)
				seen_strobe = 1;
			for (int k = 0; k < N_SLAVES; k++) begin
				// Idle master means every port is quiet
				if (!m_req_i.cyc || k != tgt) begin
					if (s_req_i[k] != '0)
						report_req_mismatch($sformatf("s_req_o[%0d]", k),
							s_req_i[k], '0);
				end else if (s_req_i[k] != '0) begin
					if (s_req_i[k] != m_req_i)
						report_req_mismatch($sformatf("s_req_o[%0d]", k),
							s_req_i[k], m_req_i);
					else
						routed = 1;
				end
			end
			if (m_req_i.cyc && m_req_i.stb && (m_rsp_i.ack || m_rsp_i.err)) begin
				n_err = errors;
				if (tgt == 4) begin
					exp_dat = 32'h0;
					if (!m_rsp_i.err || m_rsp_i.ack)
						report_mismatch("m_rsp_o.err", {31'h0, m_rsp_i.err}, 32'h1);
				end else begin
					exp_dat = shadow[tgt][m_req_i.adr[15:2]];
					if (!m_rsp_i.ack || m_rsp_i.err)
						report_mismatch("m_rsp_o.ack", {31'h0, m_rsp_i.ack}, 32'h1);
					if (!routed) begin
						$display("Slave %0d never saw the strobe at t=%0t", tgt, $time);
						errors++;
					end
					if (m_req_i.we)
						shadow[tgt][m_req_i.adr[15:2]] = m_req_i.dat_w;
				end
				// Unmapped accesses return zero data for reads and writes alike
				if ((!m_req_i.we || tgt == 4) && m_rsp_i.dat_r != exp_dat)
					report_mismatch("m_rsp_o.dat_r", m_rsp_i.dat_r, exp_dat);
				tests++;
				$display("test %0d %s adr %h target %0d %s", tests,
					m_req_i.we ? "write" : "read", m_req_i.adr, tgt,
					(errors == n_err) ? "ok" : "error");
				routed = 0;
			end
		end
	end

	assign tests_o  = tests;
	assign errors_o = errors;

endmodule

// File: tb_wb_interconnect.sv
`timescale 1ns/1ps
// Testbench for the 1x4 Wishbone interconnect
// Master driver, four slave memories with random wait states and a watchdog
module tb_wb_interconnect;
	import wb_ic_pkg::*;

	localparam int MAX_WAIT       = 3;
	localparam int N_WINDOW_TESTS = 2 * N_SLAVES;
	localparam int N_UNMAPPED     = 4;
	localparam int N_MIXED        = 36;
	localparam int N_TESTS        = N_WINDOW_TESTS + N_UNMAPPED + N_MIXED;
	// Strobe, decode, wait states, ack, idle and some slack
	localparam int CYCLES_PER_ACCESS = 4 + MAX_WAIT + 3;
	localparam int WATCHDOG_NS = (N_TESTS * CYCLES_PER_ACCESS + 40) * 40;

	logic    clk;
	logic    rstn;
	wb_req_t m_req;
	wb_rsp_t m_rsp;
	wb_req_t s_req [N_SLAVES];
	wb_rsp_t s_rsp [N_SLAVES];
	int      tests;
	int      errors;

	// Slave memories
	logic [31:0] mem [N_SLAVES][16384];
	int unsigned wait_left [N_SLAVES];
	bit          busy [N_SLAVES];

	// Outside every window
	logic [31:0] unmapped [N_UNMAPPED] = '{
		32'h0000_2000, 32'h0002_0000, 32'h8001_0000, 32'hFFFF_FFF0
	};

	wb_interconnect_1x4 u_dut (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp),
		.s_req_o (s_req),
		.s_rsp_i (s_rsp)
	);

	wb_ic_checker u_checker (
		.clk      (clk),
		.rstn     (rstn),
		.m_req_i  (m_req),
		.m_rsp_i  (m_rsp),
		.s_req_i  (s_req),
		.tests_o  (tests),
		.errors_o (errors)
	);

	always #20 clk = ~clk;

	// Slave models, ack after 0 to MAX_WAIT wait cycles
	always @(posedge clk) begin
		wb_rsp_t rsp_next;
		for (int k = 0; k < N_SLAVES; k++) begin
			if (!rstn) begin
				s_rsp[k] <= '0;
				busy[k] = 0;
			end else if (s_rsp[k].ack) begin
				s_rsp[k] <= '0;
			end else if (s_req[k].cyc && s_req[k].stb) begin
				if (!busy[k]) begin
					busy[k] = 1;
					wait_left[k] = $urandom_range(MAX_WAIT, 0);
				end
				if (wait_left[k] == 0) begin
					busy[k] = 0;
					rsp_next = '0;
					rsp_next.ack = 1'b1;
					if (s_req[k].we)
						mem[k][s_req[k].adr[15:2]] <= s_req[k].dat_w;
					else
						rsp_next.dat_r = mem[k][s_req[k].adr[15:2]];
					s_rsp[k] <= rsp_next;
				end else begin
					wait_left[k]--;
				end
			end
		end
	end

	// Word-aligned random address inside window k
	function automatic logic [31:0] rand_addr(input int k);
		logic [31:0] span;
		span = SLV_LIMIT[k] - SLV_BASE[k] + 32'd1;
		return SLV_BASE[k] + (($urandom % span) & 32'hFFFF_FFFC);
	endfunction

	// One classic cycle, held until ack or err
	task automatic access(input logic we, input logic [31:0] adr, input logic [31:0] wdat);
		@(negedge clk);
		m_req = '0;
		m_req.adr = adr;
		m_req.dat_w = wdat;
		m_req.sel = 4'hF;
		m_req.we = we;
		m_req.cyc = 1'b1;
		m_req.stb = 1'b1;
		do
			@(negedge clk);
		while (!(m_rsp.ack || m_rsp.err));
		// Hold through the rising edge that completes the cycle
		@(negedge clk);
		m_req = '0;
	endtask

	initial begin
		logic [31:0] adr;
		int pick;
		void'($urandom(32'h44a03a6e));
		clk = 1'b0;
		rstn = 1'b0;
		m_req = '0;
		for (int k = 0; k < N_SLAVES; k++) begin
			s_rsp[k] <= '0;
			for (int i = 0; i < 16384; i++)
				mem[k][i] <= {SLV_BASE[k][31:16], i[13:0], 2'b00} ^ 32'h5EED_0000 ^
					({SLV_BASE[k][31:16], i[13:0], 2'b00} << 7);
		end
		repeat (2) @(negedge clk);
		rstn = 1'b1;
		// Quiet cycles let the checker see the reset state
		repeat (3) @(negedge clk);
		for (int k = 0; k < N_SLAVES; k++) begin
			adr = rand_addr(k);
			access(1'b1, adr, $urandom);
			access(1'b0, adr, 32'h0);
		end
		for (int u = 0; u < N_UNMAPPED; u++)
			access(u[0], unmapped[u], $urandom);
		for (int t = 0; t < N_MIXED; t++) begin
			pick = $urandom_range(N_SLAVES, 0);
			if (pick < N_SLAVES)
				adr = rand_addr(pick);
			else
				adr = unmapped[$urandom_range(N_UNMAPPED - 1, 0)];
			access($urandom_range(1, 0) == 1, adr, $urandom);
		end
		repeat (3) @(negedge clk);
		$display("tests %0d of %0d errors %0d", tests, N_TESTS, errors);
		if (tests != N_TESTS)
			$display("Completed access count does not match the stimulus");
		if (errors == 0 && tests == N_TESTS) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: accesses did not complete within %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

endmodule

// File: project.f
wb_ic_pkg.sv
wb_addr_decode.sv
wb_req_router.sv
wb_decode_err.sv
wb_rsp_select.sv
wb_interconnect_1x4.sv
wb_ic_sva.sv
wb_ic_checker.sv
tb_wb_interconnect.sv

// File: run.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
	--top-module tb_wb_interconnect -o sim_tb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
